/* source/decomp_pkg.sv */
package decomp_pkg;

    // --------------------------------------------------
    // AHB encodings
    // --------------------------------------------------
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [2:0] HSIZE_WORD    = 3'b010;
    localparam logic [2:0] HBURST_INCR16 = 3'b111;

    // non-cacheable, non-bufferable, user data access
    localparam logic [3:0] HPROT_DATA    = 4'b0001;

    localparam int unsigned BURST_BEATS  = 16;
    localparam int unsigned BLOCK_BYTES  = 64;

    typedef logic [3:0] beat_idx_t;

    // --------------------------------------------------
    // bus and internal payloads
    // --------------------------------------------------
    typedef struct packed {
        logic        hbusreq;
        logic [31:0] haddr;
        logic [1:0]  htrans;
        logic        hwrite;
        logic [2:0]  hsize;
        logic [2:0]  hburst;
        logic [3:0]  hprot;
        logic [31:0] hwdata;
    } ahb_mst_out_t;

    typedef struct packed {
        logic        hgrant;
        logic        hready;
        logic [31:0] hrdata;
    } ahb_mst_in_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
    } burst_cmd_t;

    typedef struct packed {
        logic        valid;
        beat_idx_t   idx;
        logic [31:0] data;
    } rd_beat_t;

    // wren is one-hot over the three decompressor channels
    typedef struct packed {
        logic [2:0]  wren;
        logic        sop;
        logic        eop;
        logic [31:0] data;
    } decomp_wr_t;

endpackage

/* source/ahb_burst_master.sv */
`timescale 1ns/1ps

module ahb_burst_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  decomp_pkg::burst_cmd_t   cmd_i,
    input  decomp_pkg::ahb_mst_in_t  ahb_i,
    input  logic [31:0]              wdata_i,
    output decomp_pkg::ahb_mst_out_t ahb_o,
    output decomp_pkg::rd_beat_t     rd_beat_o,
    output logic                     wr_addr_valid_o,
    output decomp_pkg::beat_idx_t    wr_addr_idx_o,
    output logic                     done_o
);

    // address phase : | 0 | 1 | ... |14 |15 |
    // data phase    :     | 0 | ... |13 |14 |15 |
    //               FIRST_ADDR   MIDDLE     LAST_DATA
    typedef enum logic [2:0] {
        S_IDLE,
        S_BUSREQ,
        S_FIRST_ADDR,
        S_MIDDLE,
        S_LAST_DATA
    } state_t;

    state_t                state;
    logic                  hbusreq;
    logic [1:0]            htrans;
    logic                  hwrite;
    logic [31:0]           haddr;
    logic [31:0]           hwdata;
    decomp_pkg::beat_idx_t addr_cnt;
    decomp_pkg::beat_idx_t data_cnt;
    logic                  done_q;
    logic                  addr_acc;
    logic                  data_acc;
    logic                  last_addr;

    // address phase taken by the slave this cycle
    assign addr_acc  = (htrans != decomp_pkg::HTRANS_IDLE) && ahb_i.hready;
    // data phase completes this cycle
    assign data_acc  = ((state == S_MIDDLE) || (state == S_LAST_DATA)) && ahb_i.hready;
    assign last_addr = (addr_cnt == decomp_pkg::beat_idx_t'(decomp_pkg::BURST_BEATS - 1));

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            hbusreq  <= 1'b0;
            htrans   <= decomp_pkg::HTRANS_IDLE;
            hwrite   <= 1'b0;
            addr_cnt <= '0;
            data_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (addr_acc) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
            if (data_acc) begin
                data_cnt <= data_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        hbusreq  <= 1'b1;
                        hwrite   <= cmd_i.write;
                        addr_cnt <= '0;
                        data_cnt <= '0;
                        state    <= S_BUSREQ;
                    end
                end
                S_BUSREQ: begin
                    // keep requesting until the arbiter grants
                    if (ahb_i.hgrant) begin
                        htrans <= decomp_pkg::HTRANS_NONSEQ;
                        state  <= S_FIRST_ADDR;
                    end
                end
                S_FIRST_ADDR: begin
                    if (ahb_i.hready) begin
                        htrans <= decomp_pkg::HTRANS_SEQ;
                        state  <= S_MIDDLE;
                    end
                end
                S_MIDDLE: begin
                    if (ahb_i.hready && last_addr) begin
                        hbusreq <= 1'b0;
                        htrans  <= decomp_pkg::HTRANS_IDLE;
                        state   <= S_LAST_DATA;
                    end
                end
                S_LAST_DATA: begin
                    if (ahb_i.hready) begin
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // address steps one word per accepted phase, write data trails by one
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && start_i) begin
            haddr <= cmd_i.addr;
        end else if (addr_acc) begin
            haddr <= haddr + 32'd4;
        end
        if (wr_addr_valid_o) begin
            hwdata <= wdata_i;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign ahb_o = '{
        hbusreq: hbusreq,
        haddr:   haddr,
        htrans:  htrans,
        hwrite:  hwrite,
        hsize:   decomp_pkg::HSIZE_WORD,
        hburst:  decomp_pkg::HBURST_INCR16,
        hprot:   decomp_pkg::HPROT_DATA,
        hwdata:  hwdata
    };

    assign rd_beat_o = '{valid: data_acc && !hwrite, idx: data_cnt, data: ahb_i.hrdata};

    assign wr_addr_valid_o = addr_acc && hwrite;
    assign wr_addr_idx_o   = addr_cnt;
    assign done_o          = done_q;

    // first NONSEQ of a burst follows a sampled grant
    a_nonseq_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans == decomp_pkg::HTRANS_NONSEQ) && ($past(htrans) == decomp_pkg::HTRANS_IDLE)
            |-> $past(ahb_i.hgrant));

    // stalled address stays on the bus
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans != decomp_pkg::HTRANS_IDLE) && !ahb_i.hready |=> $stable(haddr));

endmodule

/* source/block_sequencer.sv */
`timescale 1ns/1ps

module block_sequencer #(
    parameter int LEN_W = 26
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  logic [LEN_W-1:0]       len_i,
    input  logic [31:0]            src_addr_i,
    input  logic [31:0]            dst_addr_i,
    input  logic                   decomp_done_i,
    input  logic                   burst_done_i,
    input  logic                   wr_addr_valid_i,
    input  decomp_pkg::beat_idx_t  wr_addr_idx_i,
    input  logic [63:0]            decomp_rdata_i,
    output logic                   done_o,
    output logic                   burst_start_o,
    output decomp_pkg::burst_cmd_t burst_cmd_o,
    output logic [3:0]             buf_addr_o,
    output logic [31:0]            wdata_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_DECOMP,
        S_WR_LO,
        S_WR_HI
    } state_t;

    state_t                 state;
    logic [LEN_W-1:0]       blk_cnt;
    logic [LEN_W-1:0]       blk_next;
    logic [31:0]            src_next;
    logic [31:0]            dst_base;
    logic                   wr_half;
    logic                   launch;
    logic                   burst_start_q;
    logic                   burst_busy;
    decomp_pkg::burst_cmd_t cmd_n;
    decomp_pkg::burst_cmd_t cmd_q;

    assign blk_next = blk_cnt + 1'b1;
    // source advances 64 bytes per block, destination 128
    assign src_next = src_addr_i + 32'(blk_next) * decomp_pkg::BLOCK_BYTES;
    assign dst_base = dst_addr_i + 32'(blk_cnt) * (2 * decomp_pkg::BLOCK_BYTES);
    assign wr_half  = (state == S_WR_HI);

    // --------------------------------------------------
    // next burst
    // --------------------------------------------------
    always_comb begin
        launch = 1'b0;
        cmd_n  = cmd_q;
        case (state)
            S_IDLE: begin
                launch = start_i && (len_i != '0);
                cmd_n  = '{addr: src_addr_i, write: 1'b0};
            end
            S_DECOMP: begin
                launch = decomp_done_i;
                cmd_n  = '{addr: dst_base, write: 1'b1};
            end
            S_WR_LO: begin
                launch = burst_done_i;
                cmd_n  = '{addr: dst_base + decomp_pkg::BLOCK_BYTES, write: 1'b1};
            end
            S_WR_HI: begin
                // read of the following block, unless this was the last one
                launch = burst_done_i && (blk_next != len_i);
                cmd_n  = '{addr: src_next, write: 1'b0};
            end
            default: begin
                launch = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            blk_cnt       <= '0;
            burst_start_q <= 1'b0;
            burst_busy    <= 1'b0;
        end else begin
            burst_start_q <= launch;
            // outstanding from the start pulse until the done pulse
            if (burst_start_q) begin
                burst_busy <= 1'b1;
            end else if (burst_done_i) begin
                burst_busy <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (launch) begin
                        blk_cnt <= '0;
                        state   <= S_READ;
                    end
                end
                S_READ: begin
                    if (burst_done_i) begin
                        state <= S_DECOMP;
                    end
                end
                S_DECOMP: begin
                    if (decomp_done_i) begin
                        state <= S_WR_LO;
                    end
                end
                S_WR_LO: begin
                    if (burst_done_i) begin
                        state <= S_WR_HI;
                    end
                end
                S_WR_HI: begin
                    if (burst_done_i) begin
                        if (blk_next == len_i) begin
                            state <= S_IDLE;
                        end else begin
                            blk_cnt <= blk_next;
                            state   <= S_READ;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_q <= cmd_n;
        end
    end

    // --------------------------------------------------
    // write data from the output buffer
    // --------------------------------------------------
    // two beats per 64-bit entry, eight entries per burst
    assign buf_addr_o = {wr_half, wr_addr_idx_i[3:1]};

    always_comb begin
        wdata_o = '0;
        if (wr_addr_valid_i) begin
            wdata_o = wr_addr_idx_i[0] ? decomp_rdata_i[63:32] : decomp_rdata_i[31:0];
        end
    end

    assign burst_start_o = burst_start_q;
    assign burst_cmd_o   = cmd_q;
    // start masks done so a status poll right after a command sees busy
    assign done_o        = (state == S_IDLE) && !start_i;

    // one burst in flight at a time
    a_one_burst: assert property (@(posedge clk) disable iff (!rst_n)
        burst_start_o |-> !burst_busy);

endmodule

/* source/decomp_dispatch.sv */
`timescale 1ns/1ps

module decomp_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  decomp_pkg::rd_beat_t   rd_beat_i,
    output decomp_pkg::decomp_wr_t decomp_o
);

    logic [1:0]  chan_q;
    logic [1:0]  chan_sel;
    logic [2:0]  wren_q;
    logic        sop_q;
    logic        eop_q;
    logic [31:0] data_q;
    logic        first_beat;
    logic        last_beat;

    assign first_beat = rd_beat_i.valid && (rd_beat_i.idx == '0);
    assign last_beat  = rd_beat_i.valid &&
        (rd_beat_i.idx == decomp_pkg::beat_idx_t'(decomp_pkg::BURST_BEATS - 1));

    // header decode on beat 0, held for the rest of the block
    always_comb begin
        chan_sel = chan_q;
        if (first_beat) begin
            if (rd_beat_i.data[31]) begin
                chan_sel = 2'd0;
            end else if (!rd_beat_i.data[30]) begin
                chan_sel = 2'd1;
            end else begin
                chan_sel = 2'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_q <= 2'd0;
            wren_q <= 3'b000;
            sop_q  <= 1'b0;
            eop_q  <= 1'b0;
        end else begin
            chan_q <= chan_sel;
            wren_q <= rd_beat_i.valid ? (3'b001 << chan_sel) : 3'b000;
            sop_q  <= first_beat;
            eop_q  <= last_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_beat_i.valid) begin
            data_q <= rd_beat_i.data;
        end
    end

    assign decomp_o = '{wren: wren_q, sop: sop_q, eop: eop_q, data: data_q};

    a_wren_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (wren_q != 3'b000) |-> $onehot(wren_q));

endmodule

/* source/decomp_engine_top.sv */
`timescale 1ns/1ps

module decomp_engine_top #(
    parameter int LEN_W = 26
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              src_addr_i,
    input  logic [31:0]              dst_addr_i,
    input  logic [LEN_W-1:0]         len_i,
    input  logic                     start_i,
    output logic                     done_o,
    output decomp_pkg::ahb_mst_out_t ahb_o,
    input  decomp_pkg::ahb_mst_in_t  ahb_i,
    output decomp_pkg::decomp_wr_t   decomp_o,
    input  logic                     decomp_done_i,
    output logic [3:0]               buf_addr_o,
    input  logic [63:0]              decomp_rdata_i
);

    logic                   burst_start;
    logic                   burst_done;
    decomp_pkg::burst_cmd_t burst_cmd;
    decomp_pkg::rd_beat_t   rd_beat;
    logic                   wr_addr_valid;
    decomp_pkg::beat_idx_t  wr_addr_idx;
    logic [31:0]            wdata;

    // --------------------------------------------------
    // block phases and buffer addressing
    // --------------------------------------------------
    block_sequencer #(
        .LEN_W(LEN_W)
    ) u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .len_i           (len_i),
        .src_addr_i      (src_addr_i),
        .dst_addr_i      (dst_addr_i),
        .decomp_done_i   (decomp_done_i),
        .burst_done_i    (burst_done),
        .wr_addr_valid_i (wr_addr_valid),
        .wr_addr_idx_i   (wr_addr_idx),
        .decomp_rdata_i  (decomp_rdata_i),
        .done_o          (done_o),
        .burst_start_o   (burst_start),
        .burst_cmd_o     (burst_cmd),
        .buf_addr_o      (buf_addr_o),
        .wdata_o         (wdata)
    );

    // bus side, one INCR16 at a time
    ahb_burst_master u_mst (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (burst_start),
        .cmd_i           (burst_cmd),
        .ahb_i           (ahb_i),
        .wdata_i         (wdata),
        .ahb_o           (ahb_o),
        .rd_beat_o       (rd_beat),
        .wr_addr_valid_o (wr_addr_valid),
        .wr_addr_idx_o   (wr_addr_idx),
        .done_o          (burst_done)
    );

    decomp_dispatch u_disp (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_beat_i (rd_beat),
        .decomp_o  (decomp_o)
    );

endmodule

/* tests/ahb_mem_model.sv */
`timescale 1ns/1ps

module ahb_mem_model #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  decomp_pkg::ahb_mst_out_t ahb_i,
    input  logic                     grant_stall_i,
    input  logic                     ready_stall_i,
    input  logic                     load_en_i,
    input  logic [ADDR_W-1:0]        load_idx_i,
    input  logic [31:0]              load_data_i,
    input  logic [ADDR_W-1:0]        peek_idx_i,
    output logic [31:0]              peek_data_o,
    output decomp_pkg::ahb_mst_in_t  ahb_o
);

    logic [31:0]       mem [0:(1 << ADDR_W) - 1];
    logic              hgrant;
    logic              hready;
    logic              dp_valid;
    logic              dp_write;
    logic [ADDR_W-1:0] dp_idx;
    logic [31:0]       hrdata;

    assign hready = !ready_stall_i;
    // read data only during a read data phase
    assign hrdata = (dp_valid && !dp_write) ? mem[dp_idx] : 32'h0;

    assign ahb_o = '{hgrant: hgrant, hready: hready, hrdata: hrdata};

    // backdoor read for the testbench
    assign peek_data_o = mem[peek_idx_i];

    // --------------------------------------------------
    // arbiter and address/data pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hgrant   <= 1'b0;
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_idx   <= '0;
        end else begin
            // grant stays with the master once given, until it stops requesting
            hgrant <= ahb_i.hbusreq && (hgrant || !grant_stall_i);
            if (hready) begin
                dp_valid <= ahb_i.htrans[1];
                dp_write <= ahb_i.hwrite;
                dp_idx   <= ahb_i.haddr[ADDR_W+1:2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && hready && dp_valid && dp_write) begin
            mem[dp_idx] <= ahb_i.hwdata;
        end else if (load_en_i) begin
            mem[load_idx_i] <= load_data_i;
        end
    end

endmodule

/* tests/decomp_engine_tb.sv */
`timescale 1ns/1ps

module decomp_engine_tb;

    localparam int          LEN_W   = 26;
    localparam int          TIMEOUT = 20000;
    localparam logic [31:0] SRC1    = 32'h0000_1000;
    localparam logic [31:0] DST1    = 32'h0000_2000;
    localparam logic [31:0] DST2    = 32'h0000_2800;
    localparam logic [31:0] SRC3    = 32'h0000_0400;
    localparam logic [31:0] DST3    = 32'h0000_3000;

    logic                     clk;
    logic                     rst_n;
    logic [31:0]              src_addr;
    logic [31:0]              dst_addr;
    logic [LEN_W-1:0]         len;
    logic                     start;
    logic                     done;
    decomp_pkg::ahb_mst_out_t ahb_m;
    decomp_pkg::ahb_mst_in_t  ahb_s;
    decomp_pkg::decomp_wr_t   dec_wr;
    logic [3:0]               buf_addr;
    logic [63:0]              buf_rdata;

    logic                     stall_en;
    logic                     load_en;
    logic [11:0]              load_idx;
    logic [31:0]              load_data;
    logic [11:0]              peek_idx;
    logic [31:0]              peek_data;

    // background drivers own these
    logic                     grant_stall = 1'b0;
    logic                     ready_stall = 1'b0;
    logic                     decomp_done = 1'b0;
    logic [31:0]              lfsr        = 32'hed03_c174;
    int                       eop_cnt     = 0;
    int                       eop_acked   = 0;

    decomp_pkg::ahb_mst_out_t bus_q[$];
    decomp_pkg::decomp_wr_t   disp_q[$];

    decomp_engine_top #(
        .LEN_W(LEN_W)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr),
        .dst_addr_i     (dst_addr),
        .len_i          (len),
        .start_i        (start),
        .done_o         (done),
        .ahb_o          (ahb_m),
        .ahb_i          (ahb_s),
        .decomp_o       (dec_wr),
        .decomp_done_i  (decomp_done),
        .buf_addr_o     (buf_addr),
        .decomp_rdata_i (buf_rdata)
    );

    ahb_mem_model #(
        .ADDR_W(12)
    ) u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .ahb_i         (ahb_m),
        .grant_stall_i (grant_stall),
        .ready_stall_i (ready_stall),
        .load_en_i     (load_en),
        .load_idx_i    (load_idx),
        .load_data_i   (load_data),
        .peek_idx_i    (peek_idx),
        .peek_data_o   (peek_data),
        .ahb_o         (ahb_s)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // models and helpers
    // --------------------------------------------------
    // output buffer entry, same for every block
    function automatic logic [63:0] buf_entry(input logic [3:0] e);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {16'h1CE0, 4'h0, e, 4'h0, ~e};
        hi = {8'hD7, e, 4'h9, ~e, e, 8'h3B};
        buf_entry = {hi, lo};
    endfunction

    assign buf_rdata = buf_entry(buf_addr);

    // source word, header bits forced on the first word of a block
    function automatic logic [31:0] src_word(input logic [31:0] addr, input logic head,
                                             input int chan);
        logic [31:0] w;
        w = {addr[15:0] ^ 16'h5AC3, ~addr[15:0]};
        if (head) begin
            case (chan)
                0:       w[31]    = 1'b1;
                1:       w[31:30] = 2'b00;
                default: w[31:30] = 2'b01;
            endcase
        end
        src_word = w;
    endfunction

    function automatic int chan_from_header(input logic [31:0] w);
        if (w[31]) begin
            chan_from_header = 0;
        end else if (w[30]) begin
            chan_from_header = 2;
        end else begin
            chan_from_header = 1;
        end
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    task automatic load_word(input logic [11:0] idx, input logic [31:0] data);
        load_idx  = idx;
        load_data = data;
        load_en   = 1'b1;
        advance();
        load_en = 1'b0;
    endtask

    task automatic peek_word(input logic [11:0] idx, output logic [31:0] data);
        peek_idx = idx;
        #1;
        data = peek_data;
    endtask

    task automatic preload_block(input logic [31:0] src, input int chan);
        int k;
        logic [31:0] a;
        for (k = 0; k < 16; k++) begin
            a = src + 32'(4 * k);
            load_word(a[13:2], src_word(a, k == 0, chan));
        end
    endtask

    task automatic wait_done();
        int i;
        for (i = 0; i < TIMEOUT; i++) begin
            advance();
            if (done) begin
                break;
            end
        end
        if (!done) begin
            report_timeout("done_o at the end of a job");
        end
    endtask

    task automatic run_job(input logic [31:0] src, input logic [31:0] dst,
                           input logic [LEN_W-1:0] n);
        src_addr = src;
        dst_addr = dst;
        len      = n;
        start    = 1'b1;
        advance();
        start = 1'b0;
        compare_value("done_o after start", done, 1'b0);
        wait_done();
    endtask

    // bus addresses and dispatched words of one block
    task automatic verify_block(input int abase, input int dbase, input logic [31:0] src,
                                input logic [31:0] dst, input int chan);
        decomp_pkg::ahb_mst_out_t t;
        decomp_pkg::decomp_wr_t   w;
        logic [32:0]              exp_a;
        logic [1:0]               exp_t;
        logic [2:0]               exp_en;
        int                       k;
        exp_en = 3'b001 << chan_from_header(src_word(src, 1'b1, chan));
        for (k = 0; k < 48; k++) begin
            t = bus_q[abase + k];
            if (k < 16) begin
                exp_a = {1'b0, src + 32'(4 * k)};
            end else begin
                exp_a = {1'b1, dst + 32'(4 * (k - 16))};
            end
            // each burst opens with NONSEQ, the other 15 beats are SEQ
            exp_t = (k % 16 == 0) ? decomp_pkg::HTRANS_NONSEQ : decomp_pkg::HTRANS_SEQ;
            compare_value($sformatf("haddr[%0d]", k), t.haddr, exp_a[31:0]);
            compare_value($sformatf("hwrite[%0d]", k), t.hwrite, exp_a[32]);
            compare_value($sformatf("htrans[%0d]", k), t.htrans, exp_t);
            compare_value("hsize", t.hsize, decomp_pkg::HSIZE_WORD);
            compare_value("hburst", t.hburst, decomp_pkg::HBURST_INCR16);
            compare_value("hprot", t.hprot, decomp_pkg::HPROT_DATA);
        end
        for (k = 0; k < 16; k++) begin
            w = disp_q[dbase + k];
            compare_value($sformatf("decomp_o.wren[%0d]", k), w.wren, exp_en);
            compare_value($sformatf("decomp_o.data[%0d]", k), w.data,
                          src_word(src + 32'(4 * k), k == 0, chan));
            compare_value($sformatf("decomp_o.sop[%0d]", k), w.sop, k == 0);
            compare_value($sformatf("decomp_o.eop[%0d]", k), w.eop, k == 15);
        end
    endtask

    // word n is the low half of entry n/2 when n is even, the high half otherwise
    task automatic verify_dest(input logic [31:0] dst);
        logic [31:0] d;
        logic [63:0] e;
        logic [31:0] a;
        int          n;
        for (n = 0; n < 32; n++) begin
            a = dst + 32'(4 * n);
            peek_word(a[13:2], d);
            e = buf_entry(4'(n / 2));
            compare_value($sformatf("mem[%h]", a), d, (n % 2 == 1) ? e[63:32] : e[31:0]);
        end
    endtask

    // --------------------------------------------------
    // background drivers and monitors
    // --------------------------------------------------
    always @(posedge clk) begin : drive_bg
        logic en;
        logic b0;
        logic b1;
        logic b2;
        en = stall_en;
        #1;
        if (en) begin
            take_bit(b0);
            take_bit(b1);
            take_bit(b2);
            grant_stall = b0;
            ready_stall = b1 & b2;
        end else begin
            grant_stall = 1'b0;
            ready_stall = 1'b0;
        end
        // decompressor finishes right after the last word
        if (eop_cnt != eop_acked) begin
            decomp_done = 1'b1;
            eop_acked   = eop_acked + 1;
        end else begin
            decomp_done = 1'b0;
        end
    end

    always @(negedge clk) begin : watch_bus
        if (rst_n && (ahb_m.htrans != decomp_pkg::HTRANS_IDLE) && ahb_s.hready) begin
            bus_q.push_back(ahb_m);
        end
    end

    always @(negedge clk) begin : watch_decomp
        if (rst_n && (dec_wr.wren != 3'b000)) begin
            disp_q.push_back(dec_wr);
            if (dec_wr.eop) begin
                eop_cnt = eop_cnt + 1;
            end
        end
    end

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_state();
        compare_value("done_o", done, 1'b1);
        compare_value("hbusreq", ahb_m.hbusreq, 1'b0);
        compare_value("htrans", ahb_m.htrans, decomp_pkg::HTRANS_IDLE);
        compare_value("decomp_o.wren", dec_wr.wren, 3'b000);
        compare_value("decomp_o.sop", dec_wr.sop, 1'b0);
        compare_value("decomp_o.eop", dec_wr.eop, 1'b0);
    endtask

    task automatic zero_length_start();
        int i;
        len   = '0;
        start = 1'b1;
        #1;
        // start masks done even when the command is ignored
        compare_value("done_o during start", done, 1'b0);
        advance();
        start = 1'b0;
        for (i = 0; i < 20; i++) begin
            advance();
            compare_value("done_o", done, 1'b1);
            compare_value("hbusreq", ahb_m.hbusreq, 1'b0);
        end
        compare_value("bus transfer count", bus_q.size(), 0);
    endtask

    task automatic single_block_read();
        int ab;
        int db;
        preload_block(SRC1, 0);
        ab = bus_q.size();
        db = disp_q.size();
        run_job(SRC1, DST1, 1);
        compare_value("bus transfer count", bus_q.size(), ab + 48);
        compare_value("decomp_o word count", disp_q.size(), db + 16);
        verify_block(ab, db, SRC1, DST1, 0);
    endtask

    task automatic write_back();
        run_job(SRC1, DST2, 1);
        verify_dest(DST2);
    endtask

    task automatic multi_block_stress();
        int ab;
        int db;
        int b;
        for (b = 0; b < 3; b++) begin
            preload_block(SRC3 + 32'(64 * b), b);
        end
        ab       = bus_q.size();
        db       = disp_q.size();
        stall_en = 1'b1;
        run_job(SRC3, DST3, 3);
        stall_en = 1'b0;
        compare_value("bus transfer count", bus_q.size(), ab + 3 * 48);
        compare_value("decomp_o word count", disp_q.size(), db + 3 * 16);
        for (b = 0; b < 3; b++) begin
            verify_block(ab + 48 * b, db + 16 * b, SRC3 + 32'(64 * b),
                         DST3 + 32'(128 * b), b);
            verify_dest(DST3 + 32'(128 * b));
        end
        compare_value("done_o", done, 1'b1);
    endtask

    initial begin
        int i;
        clk       = 1'b0;
        rst_n     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        len       = '0;
        start     = 1'b0;
        stall_en  = 1'b0;
        load_en   = 1'b0;
        load_idx  = '0;
        load_data = '0;
        peek_idx  = '0;
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        reset_state();
        zero_length_start();
        single_block_read();
        write_back();
        multi_block_stress();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sim.f */
source/decomp_pkg.sv
source/ahb_burst_master.sv
source/block_sequencer.sv
source/decomp_dispatch.sv
source/decomp_engine_top.sv
tests/ahb_mem_model.sv
tests/decomp_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module decomp_engine_tb -f sim.f -o decomp_engine_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/decomp_engine_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi

echo "pass line not found in the output"
exit 1
